//--- list.f
+incdir+hdl
+incdir+verification
hdl/simd_alu_pkg.sv
hdl/alu_decode.sv
hdl/alu_lane.sv
hdl/alu_lane_array.sv
hdl/alu_result_stage.sv
hdl/simd_alu.sv
verification/simd_alu_tb.sv

//--- Makefile
TOP := simd_alu_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module simd_alu -f list.f
	verilator --lint-only --timing --timescale 1ns/1ps --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --assert --top-module $(TOP) \
		-f list.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verification/simd_alu_ref.svh
// Reference functions for expected SIMD ALU element and word results and saturation

`ifndef SIMD_ALU_REF_SVH
`define SIMD_ALU_REF_SVH

function automatic logic [63:0] elem_mask(input int unsigned ew);
  return (ew >= 64) ? '1 : (64'd1 << ew) - 64'd1;
endfunction

// Value of the low ew bits on a 66-bit signed scale
function automatic logic signed [65:0] extend(input logic [63:0] x, input int unsigned ew,
                                              input bit sgn);
  logic signed [65:0] v;
  for (int i = 0; i < 66; i++) begin
    if (i < ew) v[i] = x[i];
    else v[i] = sgn & x[ew-1];
  end
  return v;
endfunction

function automatic logic [63:0] elem_expected(input alu_op_e op, input int unsigned ew,
                                              input logic [63:0] a, input logic [63:0] b,
                                              output logic sat);
  logic [63:0]        mask;
  logic signed [65:0] sa, sb, hi, lo, full;
  bit                 sgn;
  int unsigned        sh;
  logic [63:0]        r;
  mask = elem_mask(ew);
  sgn  = op inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
  sa   = extend(a, ew, sgn);
  sb   = extend(b, ew, sgn);
  hi   = sgn ? $signed({2'b00, mask >> 1}) : $signed({2'b00, mask});
  lo   = sgn ? -hi - 66'sd1 : 66'sd0;
  sh   = a[5:0] & (ew - 1);
  sat  = 1'b0;
  r    = '0;
  case (op)
    VAND  : r = a & b;
    VOR   : r = a | b;
    VXOR  : r = a ^ b;
    VADD  : r = a + b;
    VSUB  : r = b - a;
    VRSUB : r = a - b;
    VSADDU, VSADD, VSSUBU, VSSUB: begin
      // True result, clamped into the element range
      full = (op inside {VSADDU, VSADD}) ? sa + sb : sb - sa;
      if (full > hi) begin
        r   = hi[63:0];
        sat = 1'b1;
      end else if (full < lo) begin
        r   = lo[63:0];
        sat = 1'b1;
      end else begin
        r = full[63:0];
      end
    end
    VMINU, VMIN     : r = (sb < sa) ? b : a;
    VMAXU, VMAX     : r = (sb < sa) ? a : b;
    VMSEQ           : r = 64'(sb == sa);
    VMSNE           : r = 64'(sb != sa);
    VMSLTU, VMSLT   : r = 64'(sb < sa);
    VMSLEU, VMSLE   : r = 64'(sb <= sa);
    VMSGTU, VMSGT   : r = 64'(sb > sa);
    VSLL            : r = b << sh;
    VSRL            : r = (b & mask) >> sh;
    VSRA: begin
      full = extend(b, ew, 1'b1) >>> sh;
      r    = full[63:0];
    end
    default: ;
  endcase
  return r & mask;
endfunction

function automatic logic [63:0] word_expected(input alu_op_e op, input vew_e vew,
                                              input logic [63:0] a, input logic [63:0] b,
                                              output logic sat);
  int unsigned ew;
  logic [63:0] mask, res, r;
  logic        s;
  ew   = 8 << int'(vew);
  mask = elem_mask(ew);
  res  = '0;
  sat  = 1'b0;
  for (int k = 0; k < 64 / ew; k++) begin
    r   = elem_expected(op, ew, (a >> (k * ew)) & mask, (b >> (k * ew)) & mask, s);
    res = res | (r << (k * ew));
    sat = sat | s;
  end
  return res;
endfunction

`endif

//--- verification/simd_alu_tb.sv
// SIMD ALU testbench with clock, reset, stimulus, scoreboard, checker and timeout

module simd_alu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import simd_alu_pkg::*;

  `include "simd_alu_ref.svh"

  typedef struct {
    string       test;
    alu_op_e     op;
    vew_e        vew;
    elen_t       result;
    logic        sat;
    int unsigned sent;
  } expect_t;

  localparam int unsigned n_rand       = 8;
  localparam int unsigned n_sat_rand   = 4;
  localparam int unsigned num_requests = 9 * 4 * n_rand + 4 * 4 * (6 + n_sat_rand) +
                                         12 * 4 * 8 + 6;
  localparam int unsigned cycle_limit  = 2 * num_requests + 100;

  logic    clk_i = 1'b0;
  logic    arst_n_i;
  logic    valid_i;
  alu_op_e op_i;
  vew_e    vew_i;
  elen_t   operand_a_i;
  elen_t   operand_b_i;
  logic    vxsat_clr_i;
  logic    valid_o;
  elen_t   result_o;
  logic    vxsat_o;

  alu_op_e basic_ops [9]  = '{VAND, VOR, VXOR, VADD, VSUB, VRSUB, VSLL, VSRL, VSRA};
  alu_op_e sat_ops [4]    = '{VSADDU, VSADD, VSSUBU, VSSUB};
  alu_op_e cmp_ops [12]   = '{VMINU, VMIN, VMAXU, VMAX, VMSEQ, VMSNE,
                              VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT};

  expect_t     pending[$];
  string       test_name   = "reset";
  int unsigned cycle       = 0;
  int unsigned mismatches  = 0;
  int unsigned failures    = 0;
  logic        model_vxsat = 1'b0;
  logic        clr_prev    = 1'b0;
  elen_t       last_result = '0;

  simd_alu uut (.*);

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic elen_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic elen_t replicate(input logic [63:0] e, input vew_e vew);
    int unsigned ew;
    elen_t       w;
    ew = 8 << int'(vew);
    w  = '0;
    for (int k = 0; k < 64 / ew; k++) w = w | ((e & elem_mask(ew)) << (k * ew));
    return w;
  endfunction

  task automatic expect_value(input string what, input elen_t expected, input elen_t actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_idle_outputs();
    expect_value("valid_o", '0, elen_t'(valid_o));
    expect_value("vxsat_o", '0, elen_t'(vxsat_o));
    expect_value("result_o", '0, result_o);
  endtask

  task automatic send(input alu_op_e op, input vew_e vew, input elen_t a, input elen_t b);
    expect_t e;
    logic    sat;
    @(negedge clk_i);
    valid_i     = 1'b1;
    op_i        = op;
    vew_i       = vew;
    operand_a_i = a;
    operand_b_i = b;
    vxsat_clr_i = 1'b0;
    e.test   = test_name;
    e.op     = op;
    e.vew    = vew;
    e.result = word_expected(op, vew, a, b, sat);
    e.sat    = sat;
    e.sent   = cycle;
    pending.push_back(e);
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      valid_i     = 1'b0;
      vxsat_clr_i = 1'b0;
    end
  endtask

  task automatic clear_pulse();
    @(negedge clk_i);
    valid_i     = 1'b0;
    vxsat_clr_i = 1'b1;
  endtask

  task automatic drain();
    idle(1);
    while (pending.size() != 0) idle(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checker
  ////////////////////////////////////////////////////////////////////////////

  // Reads the values settled since the previous edge
  always @(posedge clk_i) begin : p_check
    expect_t exp;
    logic    sat_now;
    cycle++;
    sat_now = 1'b0;
    if (arst_n_i && valid_o) begin
      assert (pending.size() != 0) else begin
        $display("valid_o pulsed at cycle %0d with no request outstanding", cycle);
        failures++;
      end
      if (pending.size() != 0) begin
        exp     = pending.pop_front();
        sat_now = exp.sat;
        assert (result_o === exp.result) else begin
          $display("MISMATCH %s %s ew%0d: expected %h actual %h", exp.test, exp.op.name(),
                   8 << int'(exp.vew), exp.result, result_o);
          mismatches++;
        end
        // Latched by the DUT at the next edge and seen two edges later
        assert (cycle == exp.sent + 3) else begin
          $display("Result of %s %s arrived at cycle %0d, expected at cycle %0d",
                   exp.test, exp.op.name(), cycle, exp.sent + 3);
          failures++;
        end
      end
      last_result = result_o;
    end else if (arst_n_i) begin
      assert (result_o === last_result) else begin
        $display("result_o changed at cycle %0d while valid_o was low", cycle);
        failures++;
      end
    end
    if (arst_n_i) begin
      model_vxsat = (clr_prev ? 1'b0 : model_vxsat) | sat_now;
      assert (vxsat_o === model_vxsat) else begin
        $display("MISMATCH %s vxsat_o: expected %0b actual %0b", test_name, model_vxsat,
                 vxsat_o);
        mismatches++;
      end
      clr_prev = vxsat_clr_i;
    end
  end : p_check

  // Ends a run whose results stop coming
  initial begin : p_timeout
    wait (cycle > cycle_limit);
    $display("Timeout: run went past %0d cycles with %0d results outstanding",
             cycle_limit, pending.size());
    $display("CHECKS FAILED");
    $finish;
  end : p_timeout

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_stimulus
    vew_e        vew;
    logic [63:0] mask, smax, smin, e;
    void'($urandom(32'hf2e6_234e));
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    op_i        = VAND;
    vew_i       = EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    vxsat_clr_i = 1'b0;

    repeat (5) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    arst_n_i  = 1'b1;
    test_name = "after_reset";
    idle(1);
    check_idle_outputs();

    test_name = "logic_arith_shift";
    foreach (basic_ops[o]) begin
      for (int w = 0; w < 4; w++) begin
        for (int n = 0; n < n_rand; n++) send(basic_ops[o], vew_e'(w), rand_word(), rand_word());
      end
    end
    drain();

    // Overflow edges first and random pairs after
    test_name = "saturate";
    foreach (sat_ops[o]) begin
      for (int w = 0; w < 4; w++) begin
        vew  = vew_e'(w);
        mask = elem_mask(8 << w);
        smax = mask >> 1;
        smin = smax + 64'd1;
        send(sat_ops[o], vew, replicate(smax, vew), replicate(64'd1, vew));
        send(sat_ops[o], vew, replicate(smin, vew), replicate(mask, vew));
        send(sat_ops[o], vew, replicate(64'd1, vew), replicate(smin, vew));
        send(sat_ops[o], vew, replicate(smin, vew), replicate(smax, vew));
        send(sat_ops[o], vew, replicate(mask, vew), replicate(mask, vew));
        send(sat_ops[o], vew, replicate(smax, vew), replicate(64'd0, vew));
        for (int n = 0; n < n_sat_rand; n++) send(sat_ops[o], vew, rand_word(), rand_word());
      end
    end
    drain();

    test_name = "minmax_compare";
    foreach (cmp_ops[o]) begin
      for (int w = 0; w < 4; w++) begin
        vew  = vew_e'(w);
        mask = elem_mask(8 << w);
        smax = mask >> 1;
        smin = smax + 64'd1;
        e    = rand_word() & mask;
        send(cmp_ops[o], vew, replicate(e, vew), replicate(e, vew));
        send(cmp_ops[o], vew, replicate(e, vew), replicate(e + 64'd1, vew));
        send(cmp_ops[o], vew, replicate(e, vew), replicate(e - 64'd1, vew));
        send(cmp_ops[o], vew, replicate(smin, vew), replicate(smax, vew));
        send(cmp_ops[o], vew, replicate(smax, vew), replicate(smin, vew));
        send(cmp_ops[o], vew, replicate(64'd0, vew), replicate(mask, vew));
        send(cmp_ops[o], vew, replicate(mask, vew), replicate(64'd0, vew));
        send(cmp_ops[o], vew, rand_word(), rand_word());
      end
    end
    drain();

    test_name = "sticky_vxsat";
    clear_pulse();
    drain();
    expect_value("vxsat_o after clear", '0, elen_t'(vxsat_o));
    repeat (3) send(VSADDU, EW8, replicate(64'd1, EW8), replicate(64'd2, EW8));
    drain();
    expect_value("vxsat_o without saturation", '0, elen_t'(vxsat_o));
    send(VSADDU, EW8, replicate(64'hff, EW8), replicate(64'd1, EW8));
    drain();
    expect_value("vxsat_o on saturation", 64'd1, elen_t'(vxsat_o));
    idle(4);
    expect_value("vxsat_o held", 64'd1, elen_t'(vxsat_o));
    clear_pulse();
    idle(1);
    expect_value("vxsat_o cleared", '0, elen_t'(vxsat_o));
    send(VSSUBU, EW16, replicate(64'd5, EW16), replicate(64'd1, EW16));
    drain();
    expect_value("vxsat_o on underflow", 64'd1, elen_t'(vxsat_o));
    // Clear lands on the same edge as the saturating result
    send(VSADD, EW32, replicate(64'h7fff_ffff, EW32), replicate(64'd1, EW32));
    clear_pulse();
    drain();
    expect_value("vxsat_o clear with saturation", 64'd1, elen_t'(vxsat_o));

    idle(4);
    assert (pending.size() == 0) else begin
      $display("%0d requests never produced a result", pending.size());
      failures++;
    end
    $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end : p_stimulus

endmodule : simd_alu_tb

//--- hdl/simd_alu.sv
// SIMD ALU top level with decode, lane array and result stages

module simd_alu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  simd_alu_pkg::alu_op_e  op_i,
  input  simd_alu_pkg::vew_e     vew_i,
  input  simd_alu_pkg::elen_t    operand_a_i,
  input  simd_alu_pkg::elen_t    operand_b_i,
  input  logic                   vxsat_clr_i,
  output logic                   valid_o,
  output simd_alu_pkg::elen_t    result_o,
  output logic                   vxsat_o
);

  import simd_alu_pkg::*;

  alu_req_t  req;
  logic      s1_valid;
  alu_req_t  s1_req;
  alu_ctrl_t s1_ctrl;
  logic      s2_valid;
  alu_rsp_t  s2_rsp;

  assign req = '{op: op_i, vew: vew_i, operand_a: operand_a_i, operand_b: operand_b_i};

  // Stage 1, registered request
  alu_decode i_decode (
    .clk_i, .arst_n_i, .valid_i, .req_i(req),
    .valid_o(s1_valid), .req_o(s1_req), .ctrl_o(s1_ctrl));

  alu_lane_array i_lanes (
    .valid_i(s1_valid), .req_i(s1_req), .ctrl_i(s1_ctrl),
    .valid_o(s2_valid), .rsp_o(s2_rsp));

  // Stage 2, registered result
  alu_result_stage i_result (
    .clk_i, .arst_n_i, .valid_i(s2_valid), .rsp_i(s2_rsp), .vxsat_clr_i,
    .valid_o, .result_o, .vxsat_o);

endmodule : simd_alu

//--- hdl/alu_result_stage.sv
// Output register of the SIMD ALU with the sticky saturation flag

module alu_result_stage (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  simd_alu_pkg::alu_rsp_t rsp_i,
  input  logic                   vxsat_clr_i,
  output logic                   valid_o,
  output simd_alu_pkg::elen_t    result_o,
  output logic                   vxsat_o
);

  import simd_alu_pkg::*;

  logic  valid_q;
  elen_t result_q;
  logic  vxsat_q;
  logic  sat_hit;

  assign sat_hit = valid_i && (|rsp_i.sat);

  always_ff @(posedge clk_i or negedge arst_n_i) begin : p_valid
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end : p_valid

  // Holds the last result between pulses
  always_ff @(posedge clk_i or negedge arst_n_i) begin : p_result
    if (!arst_n_i) begin
      result_q <= '0;
    end else if (valid_i) begin
      result_q <= rsp_i.result;
    end
  end : p_result

  // New saturation beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin : p_vxsat
    if (!arst_n_i) begin
      vxsat_q <= 1'b0;
    end else begin
      vxsat_q <= (vxsat_q & ~vxsat_clr_i) | sat_hit;
    end
  end : p_vxsat

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;

  a_sat_needs_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !valid_i |-> (rsp_i.sat == '0))
    else $error("alu_result_stage: saturation strobe without a valid result");

endmodule : alu_result_stage

//--- hdl/alu_lane_array.sv
// SIMD ALU lane groups for all element widths and the width select

`include "simd_alu_settings.svh"

module alu_lane_array (
  input  logic                    valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  input  simd_alu_pkg::alu_ctrl_t ctrl_i,
  output logic                    valid_o,
  output simd_alu_pkg::alu_rsp_t  rsp_o
);

  import simd_alu_pkg::*;

  localparam int unsigned w8      = $bits(elem8_t);
  localparam int unsigned w16     = $bits(elem16_t);
  localparam int unsigned w32     = $bits(elem32_t);
  localparam int unsigned w64     = $bits(elem64_t);
  localparam int unsigned lanes8  = `SIMD_ALU_DATA_WIDTH / w8;
  localparam int unsigned lanes16 = `SIMD_ALU_DATA_WIDTH / w16;
  localparam int unsigned lanes32 = `SIMD_ALU_DATA_WIDTH / w32;
  localparam int unsigned lanes64 = `SIMD_ALU_DATA_WIDTH / w64;
  localparam int unsigned strb_w  = $bits(strb_t);

  elen_t              res8, res16, res32, res64;
  logic [lanes8-1:0]  sat8;
  logic [lanes16-1:0] sat16;
  logic [lanes32-1:0] sat32;
  logic [lanes64-1:0] sat64;
  elen_t              res;
  strb_t              sat;

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < lanes8; i++) begin : g_lane8
    alu_lane #(.elem_t(elem8_t)) i_lane (
      .a_i(req_i.operand_a[w8*i +: w8]), .b_i(req_i.operand_b[w8*i +: w8]),
      .ctrl_i(ctrl_i), .res_o(res8[w8*i +: w8]), .sat_o(sat8[i]));
  end

  for (genvar i = 0; i < lanes16; i++) begin : g_lane16
    alu_lane #(.elem_t(elem16_t)) i_lane (
      .a_i(req_i.operand_a[w16*i +: w16]), .b_i(req_i.operand_b[w16*i +: w16]),
      .ctrl_i(ctrl_i), .res_o(res16[w16*i +: w16]), .sat_o(sat16[i]));
  end

  for (genvar i = 0; i < lanes32; i++) begin : g_lane32
    alu_lane #(.elem_t(elem32_t)) i_lane (
      .a_i(req_i.operand_a[w32*i +: w32]), .b_i(req_i.operand_b[w32*i +: w32]),
      .ctrl_i(ctrl_i), .res_o(res32[w32*i +: w32]), .sat_o(sat32[i]));
  end

  for (genvar i = 0; i < lanes64; i++) begin : g_lane64
    alu_lane #(.elem_t(elem64_t)) i_lane (
      .a_i(req_i.operand_a[w64*i +: w64]), .b_i(req_i.operand_b[w64*i +: w64]),
      .ctrl_i(ctrl_i), .res_o(res64[w64*i +: w64]), .sat_o(sat64[i]));
  end

  // Pick the group for vew, spread each sat bit over its bytes
  always_comb begin : p_select
    res = '0;
    sat = '0;
    case (req_i.vew)
      EW8: begin
        res = res8;
        for (int i = 0; i < strb_w; i++) sat[i] = sat8[i / (w8 / 8)];
      end
      EW16: begin
        res = res16;
        for (int i = 0; i < strb_w; i++) sat[i] = sat16[i / (w16 / 8)];
      end
      EW32: begin
        res = res32;
        for (int i = 0; i < strb_w; i++) sat[i] = sat32[i / (w32 / 8)];
      end
      EW64: begin
        res = res64;
        for (int i = 0; i < strb_w; i++) sat[i] = sat64[i / (w64 / 8)];
      end
      default: ;
    endcase
  end : p_select

  assign valid_o      = valid_i;
  assign rsp_o.result = valid_i ? res : '0;
  assign rsp_o.sat    = valid_i ? sat : '0;

  // No clock here, checked once the inputs have settled
  a_vew_known : assert final (!valid_i || !$isunknown(req_i.vew))
    else $error("alu_lane_array: unknown element width on a valid request");

endmodule : alu_lane_array

//--- hdl/alu_lane.sv
// One SIMD ALU element datapath, generic over the element type

module alu_lane #(
  parameter type elem_t = simd_alu_pkg::elem8_t
) (
  input  elem_t                   a_i,
  input  elem_t                   b_i,
  input  simd_alu_pkg::alu_ctrl_t ctrl_i,
  output elem_t                   res_o,
  output logic                    sat_o
);

  import simd_alu_pkg::*;

  localparam int unsigned elem_w  = $bits(elem_t);
  localparam int unsigned msb     = elem_w - 1;
  localparam int unsigned shamt_w = $clog2(elem_w);

  localparam elem_t s_max = {1'b0, {(elem_w - 1){1'b1}}};
  localparam elem_t s_min = ~s_max;

  logic [elem_w:0]    sum;
  logic [elem_w:0]    diff;
  logic               add_ovf;
  logic               sub_ovf;
  logic               less;
  logic               equal;
  logic               cmp_hit;
  logic [shamt_w-1:0] shamt;
  elem_t              sra_res;

  ////////////////////////////////////////////////////////////////////////////
  // Shared arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Extra bit holds carry out or borrow
  assign sum  = {1'b0, a_i} + {1'b0, b_i};
  assign diff = {1'b0, b_i} - {1'b0, a_i};

  // Signed overflow, true sign follows the operand
  assign add_ovf = (a_i[msb] == b_i[msb]) && (sum[msb] != a_i[msb]);
  assign sub_ovf = (a_i[msb] != b_i[msb]) && (diff[msb] != b_i[msb]);

  // b against a, sign bit extended only for signed ops
  assign less  = $signed({ctrl_i.is_signed & b_i[msb], b_i}) <
                 $signed({ctrl_i.is_signed & a_i[msb], a_i});
  assign equal = (a_i == b_i);

  assign shamt   = a_i[shamt_w-1:0];
  assign sra_res = $signed(b_i) >>> shamt;

  always_comb begin : p_cmp
    case (ctrl_i.cmp_kind)
      CMP_NE  : cmp_hit = ~equal;
      CMP_LT  : cmp_hit = less;
      CMP_LE  : cmp_hit = less | equal;
      CMP_GT  : cmp_hit = ~(less | equal);
      default : cmp_hit = equal;
    endcase
  end : p_cmp

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_result
    res_o = '0;
    sat_o = 1'b0;
    case (ctrl_i.op_class)
      CLS_LOGIC: begin
        case (ctrl_i.logic_op)
          LOP_OR  : res_o = a_i | b_i;
          LOP_XOR : res_o = a_i ^ b_i;
          default : res_o = a_i & b_i;
        endcase
      end
      CLS_ADD  : res_o = sum[msb:0];
      CLS_SUB  : res_o = diff[msb:0];
      CLS_RSUB : res_o = a_i - b_i;
      CLS_SAT_ADD: begin
        sat_o = ctrl_i.is_signed ? add_ovf : sum[elem_w];
        if (!sat_o) begin
          res_o = sum[msb:0];
        end else if (ctrl_i.is_signed) begin
          res_o = a_i[msb] ? s_min : s_max;
        end else begin
          res_o = '1;
        end
      end
      CLS_SAT_SUB: begin
        // Unsigned underflow clamps to zero
        sat_o = ctrl_i.is_signed ? sub_ovf : diff[elem_w];
        if (!sat_o) begin
          res_o = diff[msb:0];
        end else if (ctrl_i.is_signed) begin
          res_o = b_i[msb] ? s_min : s_max;
        end
      end
      CLS_MINMAX : res_o = (less ^ ctrl_i.is_max) ? b_i : a_i;
      CLS_CMP    : res_o = elem_t'(cmp_hit);
      CLS_SHIFT: begin
        case (ctrl_i.shift_kind)
          SH_SRL  : res_o = b_i >> shamt;
          SH_SRA  : res_o = sra_res;
          default : res_o = b_i << shamt;
        endcase
      end
      default: ;
    endcase
  end : p_result

endmodule : alu_lane

//--- hdl/alu_decode.sv
// Input register of the SIMD ALU and opcode decode into control fields

module alu_decode (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    valid_o,
  output simd_alu_pkg::alu_req_t  req_o,
  output simd_alu_pkg::alu_ctrl_t ctrl_o
);

  import simd_alu_pkg::*;

  alu_ctrl_t ctrl;
  logic      valid_q;
  alu_req_t  req_q;
  alu_ctrl_t ctrl_q;

  always_comb begin : p_decode
    ctrl = '0;
    ctrl.is_signed = req_i.op inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE, VMSGT, VSRA};
    ctrl.is_max    = req_i.op inside {VMAXU, VMAX};

    case (req_i.op)
      VADD                          : ctrl.op_class = CLS_ADD;
      VSUB                          : ctrl.op_class = CLS_SUB;
      VRSUB                         : ctrl.op_class = CLS_RSUB;
      VSADDU, VSADD                 : ctrl.op_class = CLS_SAT_ADD;
      VSSUBU, VSSUB                 : ctrl.op_class = CLS_SAT_SUB;
      VMINU, VMIN, VMAXU, VMAX      : ctrl.op_class = CLS_MINMAX;
      VMSEQ, VMSNE, VMSLTU, VMSLT,
      VMSLEU, VMSLE, VMSGTU, VMSGT  : ctrl.op_class = CLS_CMP;
      VSLL, VSRL, VSRA              : ctrl.op_class = CLS_SHIFT;
      default                       : ctrl.op_class = CLS_LOGIC;
    endcase

    case (req_i.op)
      VOR     : ctrl.logic_op = LOP_OR;
      VXOR    : ctrl.logic_op = LOP_XOR;
      default : ctrl.logic_op = LOP_AND;
    endcase

    case (req_i.op)
      VMSNE         : ctrl.cmp_kind = CMP_NE;
      VMSLTU, VMSLT : ctrl.cmp_kind = CMP_LT;
      VMSLEU, VMSLE : ctrl.cmp_kind = CMP_LE;
      VMSGTU, VMSGT : ctrl.cmp_kind = CMP_GT;
      default       : ctrl.cmp_kind = CMP_EQ;
    endcase

    case (req_i.op)
      VSRL    : ctrl.shift_kind = SH_SRL;
      VSRA    : ctrl.shift_kind = SH_SRA;
      default : ctrl.shift_kind = SH_SLL;
    endcase
  end : p_decode

  always_ff @(posedge clk_i or negedge arst_n_i) begin : p_valid
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end : p_valid

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin : p_payload
    if (valid_i) begin
      req_q  <= req_i;
      ctrl_q <= ctrl;
    end
  end : p_payload

  assign valid_o = valid_q;
  assign req_o   = req_q;
  assign ctrl_o  = ctrl_q;

  a_op_in_enum : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> !$isunknown(req_i.op) && (req_i.op inside {[VAND:VSRA]}))
    else $error("alu_decode: request with an opcode outside the enum");

endmodule : alu_decode

//--- hdl/simd_alu_pkg.sv
// SIMD ALU enums, element types and the request, control and response structs

`include "simd_alu_settings.svh"

package simd_alu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`SIMD_ALU_DATA_WIDTH-1:0] elen_t;
  typedef logic [`SIMD_ALU_STRB_WIDTH-1:0] strb_t;

  // Lane payloads
  typedef logic [7:0]  elem8_t;
  typedef logic [15:0] elem16_t;
  typedef logic [31:0] elem32_t;
  typedef logic [63:0] elem64_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [`SIMD_ALU_OP_WIDTH-1:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT,
    VSLL, VSRL, VSRA
  } alu_op_e;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  typedef enum logic [3:0] {
    CLS_LOGIC, CLS_ADD, CLS_SUB, CLS_RSUB,
    CLS_SAT_ADD, CLS_SAT_SUB, CLS_MINMAX, CLS_CMP, CLS_SHIFT
  } alu_class_e;

  // Compares look at b against a
  typedef enum logic [2:0] {CMP_EQ, CMP_NE, CMP_LT, CMP_LE, CMP_GT} cmp_kind_e;

  typedef enum logic [1:0] {LOP_AND, LOP_OR, LOP_XOR} logic_op_e;

  typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_kind_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    elen_t   operand_a;
    elen_t   operand_b;
  } alu_req_t;

  typedef struct packed {
    alu_class_e  op_class;
    logic        is_signed;
    logic_op_e   logic_op;
    logic        is_max;
    cmp_kind_e   cmp_kind;
    shift_kind_e shift_kind;
  } alu_ctrl_t;

  // Saturation is widened to every byte of the element
  typedef struct packed {
    elen_t result;
    strb_t sat;
  } alu_rsp_t;

endpackage : simd_alu_pkg

//--- hdl/simd_alu_settings.svh
// Datapath, byte-strobe and opcode width macros for the SIMD ALU

`ifndef SIMD_ALU_SETTINGS_SVH
`define SIMD_ALU_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// One 64-bit word per cycle
`define SIMD_ALU_DATA_WIDTH 64

// One strobe bit per byte of the word
`define SIMD_ALU_STRB_WIDTH (`SIMD_ALU_DATA_WIDTH / 8)

// Room for all opcodes
`define SIMD_ALU_OP_WIDTH 5

`endif
